/* src/calc_defs.svh */
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// Datapath widths.
`define WORD_WIDTH  32
`define DIGIT_WIDTH 8

// Stack memory, one word is kept free.
`define STACK_DEPTH 512
`define PTR_WIDTH   9

// Board inputs.
`define BTN_COUNT   4
`define SYNC_STAGES 3

`endif

/* src/calcPkg.sv */
`default_nettype none

package calcPkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_DIV  = 3'd3,
        OP_REM  = 3'd4,
        OP_POP  = 3'd5,
        OP_DUP  = 3'd6,
        OP_SWAP = 3'd7
    } opcode_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_PUSH,
        ST_EXTEND,
        ST_POP0, ST_POP1, ST_POP2,
        ST_DUP,
        ST_SWAP0, ST_SWAP1, ST_SWAP2, ST_SWAP3,
        ST_BIN0, ST_BIN1, ST_BIN2, ST_BIN3, ST_BIN4,
        ST_DIVIDE
    } ctrlState_t;

endpackage

`default_nettype wire

/* src/stackRam.sv */
`default_nettype none
`include "calc_defs.svh"

module stackRam (
    input  wire                     clk,
    input  wire                     we,
    input  wire [`PTR_WIDTH-1:0]    addr,
    input  wire [`WORD_WIDTH-1:0]   wdata,
    output logic [`WORD_WIDTH-1:0]  rdata
);
    logic [`WORD_WIDTH-1:0] mem [`STACK_DEPTH];

    // Single port, a write leaves rdata holding the last read.
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        else
            rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* src/signedDivider.sv */
`default_nettype none
`include "calc_defs.svh"

module signedDivider (
    input  wire                     clk,
    input  wire                     stb,
    input  wire                     start,
    input  wire [`WORD_WIDTH-1:0]   dividend,
    input  wire [`WORD_WIDTH-1:0]   divisor,
    output logic [`WORD_WIDTH-1:0]  quotient,
    output logic [`WORD_WIDTH-1:0]  remainder,
    output logic                    done
);
    localparam int CNT_WIDTH = $clog2(`WORD_WIDTH + 1);
    localparam logic [CNT_WIDTH-1:0] LAST_STEP = CNT_WIDTH'(`WORD_WIDTH);

    logic                       busy;
    logic [CNT_WIDTH-1:0]       stepCnt;
    logic [2*`WORD_WIDTH-1:0]   divShift;  // Divisor magnitude, walks down.
    logic [`WORD_WIDTH-1:0]     qMag;
    logic [`WORD_WIDTH-1:0]     rMag;
    logic [`WORD_WIDTH-1:0]     dividendMag;
    logic [`WORD_WIDTH-1:0]     divisorMag;
    logic                       negQ;
    logic                       negR;

    assign dividendMag = dividend[`WORD_WIDTH-1] ? -dividend : dividend;
    assign divisorMag  = divisor[`WORD_WIDTH-1] ? -divisor : divisor;

    //////////////////////////////////////////////////
    // Step counter and done pulse.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge stb) begin
        if (stb) begin
            busy    <= 1'b0;
            stepCnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                stepCnt <= '0;
            end else if (busy) begin
                stepCnt <= stepCnt + 1'b1;
                if (stepCnt == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // Lands with the last step.
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Shift, compare, subtract.
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (start) begin
            divShift <= {divisorMag, {`WORD_WIDTH{1'b0}}};
            rMag     <= dividendMag;
            qMag     <= '0;
            negQ     <= dividend[`WORD_WIDTH-1] ^ divisor[`WORD_WIDTH-1];
            negR     <= dividend[`WORD_WIDTH-1];
        end else if (busy) begin
            if ({{`WORD_WIDTH{1'b0}}, rMag} >= divShift) begin
                rMag <= rMag - divShift[`WORD_WIDTH-1:0];
                qMag <= {qMag[`WORD_WIDTH-2:0], 1'b1};
            end else begin
                qMag <= {qMag[`WORD_WIDTH-2:0], 1'b0};
            end
            divShift <= divShift >> 1;
        end
    end

    // Remainder follows the dividend sign.
    assign quotient  = negQ ? -qMag : qMag;
    assign remainder = negR ? -rMag : rMag;

    assert property (@(posedge clk) disable iff (stb) start |-> !busy)
        else $error("divider restarted while running");

endmodule

`default_nettype wire

/* src/buttonConditioner.sv */
`default_nettype none
`include "calc_defs.svh"

module buttonConditioner
    import calcPkg::*;
(
    input  wire                     clk,
    input  wire                     stb,
    input  wire [`BTN_COUNT-1:0]    btn,
    input  wire [`DIGIT_WIDTH-1:0]  sw,
    output logic                    pushPress,
    output logic                    extendPress,
    output logic                    opPress,
    output logic                    clearPress,
    output logic [`DIGIT_WIDTH-1:0] digit,
    output opcode_t                 opcode
);
    localparam int IN_WIDTH = `BTN_COUNT + `DIGIT_WIDTH;

    localparam logic [`BTN_COUNT-1:0] PUSH_BTN   = 4'b0010;
    localparam logic [`BTN_COUNT-1:0] EXTEND_BTN = 4'b0100;
    localparam logic [`BTN_COUNT-1:0] OP_BTN     = 4'b1000;
    localparam logic [`BTN_COUNT-1:0] CLEAR_BTN  = 4'b1001;

    logic [`SYNC_STAGES-1:0][IN_WIDTH-1:0] syncChain;
    logic [`BTN_COUNT-1:0]                 syncBtn;
    logic [`DIGIT_WIDTH-1:0]               syncSw;
    logic [2:0]                            single;
    logic [2:0]                            pressSeen;  // Pattern already reported.

    assign syncBtn = syncChain[`SYNC_STAGES-1][`BTN_COUNT-1:0];
    assign syncSw  = syncChain[`SYNC_STAGES-1][IN_WIDTH-1:`BTN_COUNT];
    assign single  = {syncBtn == OP_BTN, syncBtn == EXTEND_BTN, syncBtn == PUSH_BTN};

    assign digit  = syncSw;
    assign opcode = opcode_t'(syncSw[2:0]);  // Opcode on switches 2..0.

    always_ff @(posedge clk or posedge stb) begin
        if (stb) begin
            syncChain <= '0;
            pressSeen <= '0;
            {opPress, extendPress, pushPress} <= '0;
            clearPress <= 1'b0;
        end else begin
            syncChain <= {syncChain[`SYNC_STAGES-2:0], {sw, btn}};
            {opPress, extendPress, pushPress} <= single & ~pressSeen;
            clearPress <= syncBtn == CLEAR_BTN;
            if (syncBtn == '0)
                pressSeen <= '0;  // Rearm once all buttons are released.
            else
                pressSeen <= pressSeen | single;
        end
    end

    // A held button gives a single-cycle pulse.
    assert property (@(posedge clk) disable iff (stb)
        !(|({pushPress, extendPress, opPress} & $past({pushPress, extendPress, opPress}))))
        else $error("press pulse held for more than one cycle");

endmodule

`default_nettype wire

/* src/stackController.sv */
`default_nettype none
`include "calc_defs.svh"

module stackController
    import calcPkg::*;
(
    input  wire                     clk,
    input  wire                     stb,
    input  wire                     pushPress,
    input  wire                     extendPress,
    input  wire                     opPress,
    input  wire                     clearPress,
    input  wire [`DIGIT_WIDTH-1:0]  digit,
    input  var opcode_t             opcode,
    output logic                    ramWe,
    output logic [`PTR_WIDTH-1:0]   ramAddr,
    output logic [`WORD_WIDTH-1:0]  ramWdata,
    input  wire [`WORD_WIDTH-1:0]   ramRdata,
    output logic                    divStart,
    output logic [`WORD_WIDTH-1:0]  dividend,
    output logic [`WORD_WIDTH-1:0]  divisor,
    input  wire [`WORD_WIDTH-1:0]   quotient,
    input  wire [`WORD_WIDTH-1:0]   remainder,
    input  wire                     divDone,
    output logic [`PTR_WIDTH-1:0]   stackSize,
    output logic                    error,
    output logic [`WORD_WIDTH-1:0]  topValue
);
    localparam logic [`PTR_WIDTH-1:0] PTR_ONE  = `PTR_WIDTH'(1);
    localparam logic [`PTR_WIDTH-1:0] PTR_TWO  = `PTR_WIDTH'(2);
    localparam logic [`PTR_WIDTH-1:0] PTR_FULL = `PTR_WIDTH'(`STACK_DEPTH - 1);

    ctrlState_t                 state;
    ctrlState_t                 cmdState;
    logic                       cmdIllegal;
    opcode_t                    binOp;
    logic [`WORD_WIDTH-1:0]     topReg;  // Top of stack is mirrored in RAM.
    logic [`WORD_WIDTH-1:0]     extended;
    logic [`WORD_WIDTH-1:0]     digitWord;
    logic [`PTR_WIDTH-1:0]      sizeLess1;
    logic [`PTR_WIDTH-1:0]      sizeLess2;

    assign sizeLess1 = stackSize - PTR_ONE;
    assign sizeLess2 = stackSize - PTR_TWO;
    assign digitWord = {{(`WORD_WIDTH-`DIGIT_WIDTH){1'b0}}, digit};
    assign extended  = {topReg[`WORD_WIDTH-`DIGIT_WIDTH-1:0], digit};

    // Entry below the top comes straight from the RAM read port.
    assign dividend = ramRdata;
    assign divisor  = topReg;
    assign topValue = (stackSize == '0) ? '0 : topReg;

    //////////////////////////////////////////////////
    // Command decode and legality.
    //////////////////////////////////////////////////
    always_comb begin
        cmdState   = ST_IDLE;
        cmdIllegal = 1'b0;
        if (pushPress) begin
            cmdState   = ST_PUSH;
            cmdIllegal = stackSize == PTR_FULL;
        end else if (extendPress) begin
            cmdState   = ST_EXTEND;
            cmdIllegal = stackSize == '0;
        end else if (opPress) begin
            case (opcode)
                OP_POP: begin
                    cmdState   = ST_POP0;
                    cmdIllegal = stackSize == '0;
                end
                OP_DUP: begin
                    cmdState   = ST_DUP;
                    cmdIllegal = (stackSize == '0) || (stackSize == PTR_FULL);
                end
                OP_SWAP: begin
                    cmdState   = ST_SWAP0;
                    cmdIllegal = stackSize < PTR_TWO;
                end
                OP_DIV, OP_REM: begin
                    cmdState   = ST_BIN0;
                    cmdIllegal = (stackSize < PTR_TWO) || (topReg == '0);  // Zero divisor.
                end
                default: begin
                    cmdState   = ST_BIN0;
                    cmdIllegal = stackSize < PTR_TWO;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Command sequencer.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge stb) begin
        if (stb) begin
            state     <= ST_IDLE;
            binOp     <= OP_ADD;
            topReg    <= '0;
            stackSize <= '0;
            error     <= 1'b0;
            ramWe     <= 1'b0;
            ramAddr   <= '0;
            ramWdata  <= '0;
            divStart  <= 1'b0;
        end else begin
            ramWe    <= 1'b0;
            divStart <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (clearPress) begin
                        stackSize <= '0;
                        topReg    <= '0;
                        error     <= 1'b0;
                    end else if (cmdState != ST_IDLE) begin
                        binOp <= opcode;
                        error <= cmdIllegal;
                        if (!cmdIllegal)
                            state <= cmdState;
                    end
                end
                ST_PUSH: begin
                    topReg    <= digitWord;
                    ramAddr   <= stackSize;
                    ramWdata  <= digitWord;
                    ramWe     <= 1'b1;
                    stackSize <= stackSize + PTR_ONE;
                    state     <= ST_IDLE;
                end
                ST_EXTEND: begin
                    topReg   <= extended;
                    ramAddr  <= sizeLess1;
                    ramWdata <= extended;
                    ramWe    <= 1'b1;
                    state    <= ST_IDLE;
                end
                ST_DUP: begin
                    ramAddr   <= stackSize;
                    ramWdata  <= topReg;
                    ramWe     <= 1'b1;
                    stackSize <= stackSize + PTR_ONE;
                    state     <= ST_IDLE;
                end
                ST_POP0: begin
                    stackSize <= sizeLess1;
                    ramAddr   <= sizeLess2;
                    state     <= (stackSize == PTR_ONE) ? ST_IDLE : ST_POP1;
                end
                ST_POP1: state <= ST_POP2;  // RAM read latency.
                ST_POP2: begin
                    topReg <= ramRdata;
                    state  <= ST_IDLE;
                end
                ST_SWAP0: begin
                    ramAddr <= sizeLess2;
                    state   <= ST_SWAP1;
                end
                ST_SWAP1: state <= ST_SWAP2;
                ST_SWAP2: begin
                    topReg   <= ramRdata;
                    ramWdata <= topReg;  // Old top goes below.
                    ramWe    <= 1'b1;
                    state    <= ST_SWAP3;
                end
                ST_SWAP3: begin
                    ramAddr  <= sizeLess1;
                    ramWdata <= topReg;
                    ramWe    <= 1'b1;
                    state    <= ST_IDLE;
                end
                ST_BIN0: begin
                    ramAddr <= sizeLess2;
                    state   <= ST_BIN1;
                end
                ST_BIN1: state <= ST_BIN2;
                ST_BIN2: begin
                    state <= ST_BIN3;
                    case (binOp)
                        OP_ADD: topReg <= ramRdata + topReg;
                        OP_SUB: topReg <= ramRdata - topReg;
                        OP_MUL: topReg <= ramRdata * topReg;
                        OP_DIV, OP_REM: begin
                            divStart <= 1'b1;
                            state    <= ST_DIVIDE;
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
                ST_DIVIDE: begin
                    if (divDone)
                        state <= ST_BIN3;
                end
                ST_BIN3: begin
                    if (binOp == OP_DIV)
                        topReg <= quotient;
                    else if (binOp == OP_REM)
                        topReg <= remainder;
                    state <= ST_BIN4;
                end
                ST_BIN4: begin
                    ramAddr   <= sizeLess2;
                    ramWdata  <= topReg;
                    ramWe     <= 1'b1;
                    stackSize <= sizeLess1;
                    state     <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // The last RAM word is never part of the stack.
    assert property (@(posedge clk) disable iff (stb) ramWe |-> ramAddr < PTR_FULL)
        else $error("stack write at address %0d", ramAddr);

    // A zero divisor is rejected before the divider starts.
    assert property (@(posedge clk) disable iff (stb) divStart |-> divisor != '0)
        else $error("divider started with a zero divisor");

endmodule

`default_nettype wire

/* src/calcTop.sv */
`default_nettype none
`include "calc_defs.svh"

module calcTop
    import calcPkg::*;
(
    input  wire                     clk,
    input  wire                     stb,
    input  wire [`BTN_COUNT-1:0]    btn,
    input  wire [`DIGIT_WIDTH-1:0]  sw,
    output logic [7:0]              led,
    output logic [`WORD_WIDTH-1:0]  topValue
);
    logic                       pushPress;
    logic                       extendPress;
    logic                       opPress;
    logic                       clearPress;
    logic [`DIGIT_WIDTH-1:0]    digit;
    opcode_t                    opcode;

    logic                       ramWe;
    logic [`PTR_WIDTH-1:0]      ramAddr;
    logic [`WORD_WIDTH-1:0]     ramWdata;
    logic [`WORD_WIDTH-1:0]     ramRdata;

    logic                       divStart;
    logic                       divDone;
    logic [`WORD_WIDTH-1:0]     dividend;
    logic [`WORD_WIDTH-1:0]     divisor;
    logic [`WORD_WIDTH-1:0]     quotient;
    logic [`WORD_WIDTH-1:0]     remainder;

    logic [`PTR_WIDTH-1:0]      stackSize;
    logic                       error;

    assign led = {error, stackSize[6:0]};  // Error flag over the size.

    buttonConditioner u_buttonConditioner (
        .clk         (clk),
        .stb         (stb),
        .btn         (btn),
        .sw          (sw),
        .pushPress   (pushPress),
        .extendPress (extendPress),
        .opPress     (opPress),
        .clearPress  (clearPress),
        .digit       (digit),
        .opcode      (opcode)
    );

    stackController u_stackController (
        .clk         (clk),
        .stb         (stb),
        .pushPress   (pushPress),
        .extendPress (extendPress),
        .opPress     (opPress),
        .clearPress  (clearPress),
        .digit       (digit),
        .opcode      (opcode),
        .ramWe       (ramWe),
        .ramAddr     (ramAddr),
        .ramWdata    (ramWdata),
        .ramRdata    (ramRdata),
        .divStart    (divStart),
        .dividend    (dividend),
        .divisor     (divisor),
        .quotient    (quotient),
        .remainder   (remainder),
        .divDone     (divDone),
        .stackSize   (stackSize),
        .error       (error),
        .topValue    (topValue)
    );

    stackRam u_stackRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    signedDivider u_signedDivider (
        .clk       (clk),
        .stb       (stb),
        .start     (divStart),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (divDone)
    );

endmodule

`default_nettype wire

/* verification/calcChecker.sv */
`default_nettype none
`include "calc_defs.svh"

module calcChecker
    import calcPkg::*;
(
    input  wire                     clk,
    input  wire                     cmdValid,
    input  wire [`BTN_COUNT-1:0]    cmdButtons,
    input  wire [`DIGIT_WIDTH-1:0]  cmdByte,
    input  wire                     compareNow,
    input  wire [7:0]               led,
    input  wire [`WORD_WIDTH-1:0]   topValue,
    output logic [31:0]             checkCount,
    output logic [31:0]             errorCount
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ENTRIES = `STACK_DEPTH - 1;

    localparam logic [`BTN_COUNT-1:0] PUSH_BTN   = 4'b0010;
    localparam logic [`BTN_COUNT-1:0] EXTEND_BTN = 4'b0100;
    localparam logic [`BTN_COUNT-1:0] CLEAR_BTN  = 4'b1001;

    logic [`WORD_WIDTH-1:0] modelStack [$];  // Bottom entry first.
    logic                   modelError = 1'b0;
    int                     checks = 0;
    int                     errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    function automatic logic [`WORD_WIDTH-1:0] magnitude(input logic [`WORD_WIDTH-1:0] v);
        return v[`WORD_WIDTH-1] ? -v : v;
    endfunction

    // Division works on magnitudes, signs are put back afterwards.
    function automatic logic [`WORD_WIDTH-1:0] binaryResult(
        input opcode_t                op,
        input logic [`WORD_WIDTH-1:0] a,
        input logic [`WORD_WIDTH-1:0] b
    );
        logic [`WORD_WIDTH-1:0] aMag;
        logic [`WORD_WIDTH-1:0] bMag;
        aMag = magnitude(a);
        bMag = magnitude(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;  // Low word of the product.
            OP_DIV:  return (a[`WORD_WIDTH-1] ^ b[`WORD_WIDTH-1]) ?
                            -(aMag / bMag) : aMag / bMag;
            default: return a[`WORD_WIDTH-1] ? -(aMag % bMag) : aMag % bMag;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stack model.
    //////////////////////////////////////////////////
    task automatic applyCommand(
        input logic [`BTN_COUNT-1:0]   buttons,
        input logic [`DIGIT_WIDTH-1:0] value
    );
        opcode_t                op;
        logic [`WORD_WIDTH-1:0] a;
        logic [`WORD_WIDTH-1:0] b;
        int                     n;
        logic                   legal;
        op    = opcode_t'(value[2:0]);
        n     = modelStack.size();
        legal = 1'b1;
        if (buttons == CLEAR_BTN) begin
            modelStack.delete();
        end else if (buttons == PUSH_BTN) begin
            legal = n < MAX_ENTRIES;
            if (legal)
                modelStack.push_back(`WORD_WIDTH'(value));
        end else if (buttons == EXTEND_BTN) begin
            legal = n >= 1;
            if (legal)
                modelStack[n-1] = modelStack[n-1] * 256 + `WORD_WIDTH'(value);
        end else begin
            case (op)
                OP_POP: begin
                    legal = n >= 1;
                    if (legal)
                        modelStack.delete(n - 1);
                end
                OP_DUP: begin
                    legal = (n >= 1) && (n < MAX_ENTRIES);
                    if (legal)
                        modelStack.push_back(modelStack[n-1]);
                end
                OP_SWAP: begin
                    legal = n >= 2;
                    if (legal) begin
                        b = modelStack[n-1];
                        modelStack[n-1] = modelStack[n-2];
                        modelStack[n-2] = b;
                    end
                end
                default: begin
                    legal = n >= 2;
                    if (legal && (op == OP_DIV || op == OP_REM))
                        legal = modelStack[n-1] != '0;  // Zero divisor.
                    if (legal) begin
                        b = modelStack[n-1];
                        a = modelStack[n-2];
                        modelStack.delete(n - 1);
                        modelStack[n-2] = binaryResult(op, a, b);
                    end
                end
            endcase
        end
        modelError = !legal;
    endtask

    task automatic compareOutputs();
        logic [7:0]             expLed;
        logic [`WORD_WIDTH-1:0] expTop;
        expLed = {modelError, 7'(modelStack.size())};
        expTop = (modelStack.size() == 0) ? '0 : modelStack[modelStack.size() - 1];
        checks++;
        if (led !== expLed) begin
            errors++;
            $display("FAIL led expected %h actual %h at %0t", expLed, led, $time);
        end
        if (topValue !== expTop) begin
            errors++;
            $display("FAIL topValue expected %h actual %h at %0t", expTop, topValue, $time);
        end
    endtask

    always @(posedge clk) begin
        if (compareNow)
            compareOutputs();
        if (cmdValid)
            applyCommand(cmdButtons, cmdByte);
    end

endmodule

`default_nettype wire

/* verification/calcTb.sv */
`default_nettype none
`include "calc_defs.svh"

module calcTb
    import calcPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD   = 10;
    localparam int RESET_CYCLES  = 8;
    localparam int HOLD_CYCLES   = 8;
    localparam int GAP_CYCLES    = 56;
    localparam int FAST_HOLD     = 4;  // Push is done long before the fast slot ends.
    localparam int FAST_GAP      = 12;
    localparam int RANDOM_CMDS   = 300;
    localparam int DIRECTED_CMDS = 48;
    localparam int FILL_CMDS     = `STACK_DEPTH - 1;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES
                                  + (RANDOM_CMDS + DIRECTED_CMDS) * (HOLD_CYCLES + GAP_CYCLES)
                                  + FILL_CMDS * (FAST_HOLD + FAST_GAP)
                                  + 1000;

    localparam logic [`BTN_COUNT-1:0] PUSH_BTN   = 4'b0010;
    localparam logic [`BTN_COUNT-1:0] EXTEND_BTN = 4'b0100;
    localparam logic [`BTN_COUNT-1:0] OP_BTN     = 4'b1000;
    localparam logic [`BTN_COUNT-1:0] CLEAR_BTN  = 4'b1001;

    logic                       clk = 1'b0;
    logic                       stb;
    logic [`BTN_COUNT-1:0]      btn;
    logic [`DIGIT_WIDTH-1:0]    sw;
    logic [7:0]                 led;
    logic [`WORD_WIDTH-1:0]     topValue;

    logic                       cmdValid;
    logic [`BTN_COUNT-1:0]      cmdButtons;
    logic [`DIGIT_WIDTH-1:0]    cmdByte;
    logic                       compareNow;
    logic [31:0]                checkCount;
    logic [31:0]                errorCount;
    int                         cycleCount = 0;
    int                         commandCount = 0;

    always #HALF_PERIOD clk = ~clk;

    calcTop u_calcTop (
        .clk      (clk),
        .stb      (stb),
        .btn      (btn),
        .sw       (sw),
        .led      (led),
        .topValue (topValue)
    );

    calcChecker u_calcChecker (
        .clk        (clk),
        .cmdValid   (cmdValid),
        .cmdButtons (cmdButtons),
        .cmdByte    (cmdByte),
        .compareNow (compareNow),
        .led        (led),
        .topValue   (topValue),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the command sequence did not end within %0d cycles.",
                     TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Command driver, called right after a rising edge.
    //////////////////////////////////////////////////
    task automatic runCommand(
        input logic [`BTN_COUNT-1:0]   buttons,
        input logic [`DIGIT_WIDTH-1:0] value,
        input int                      holdCycles,
        input int                      gapCycles
    );
        btn        <= buttons;
        sw         <= value;
        cmdButtons <= buttons;
        cmdByte    <= value;
        cmdValid   <= 1'b1;
        commandCount++;
        @(posedge clk);
        cmdValid <= 1'b0;
        repeat (holdCycles - 1) @(posedge clk);
        btn <= '0;
        repeat (gapCycles - 1) @(posedge clk);
        compareNow <= 1'b1;  // Sampled while the controller is idle.
        @(posedge clk);
        compareNow <= 1'b0;
    endtask

    task automatic pushByte(input logic [`DIGIT_WIDTH-1:0] value);
        runCommand(PUSH_BTN, value, HOLD_CYCLES, GAP_CYCLES);
    endtask

    task automatic extendByte(input logic [`DIGIT_WIDTH-1:0] value);
        runCommand(EXTEND_BTN, value, HOLD_CYCLES, GAP_CYCLES);
    endtask

    task automatic operate(input opcode_t op);
        runCommand(OP_BTN, {5'b00000, op}, HOLD_CYCLES, GAP_CYCLES);
    endtask

    task automatic clearStack();
        runCommand(CLEAR_BTN, 8'($urandom), HOLD_CYCLES, GAP_CYCLES);
    endtask

    initial begin
        int                      pick;
        logic [`DIGIT_WIDTH-1:0] value;
        stb        <= 1'b1;
        btn        <= '0;
        sw         <= '0;
        cmdValid   <= 1'b0;
        cmdButtons <= '0;
        cmdByte    <= '0;
        compareNow <= 1'b0;
        void'($urandom(32'h4e54));
        repeat (RESET_CYCLES) @(posedge clk);
        stb <= 1'b0;
        repeat (2) @(posedge clk);
        compareNow <= 1'b1;  // Empty stack straight out of reset.
        @(posedge clk);
        compareNow <= 1'b0;

        // Underflow, then a legal push clears the flag.
        operate(OP_POP);
        extendByte(8'h33);
        pushByte(8'h12);
        operate(OP_ADD);
        operate(OP_SWAP);
        clearStack();

        // Most negative dividend over minus one, then its remainder by seven.
        pushByte(8'h80);
        repeat (3) extendByte(8'h00);
        pushByte(8'hff);
        repeat (3) extendByte(8'hff);
        operate(OP_DIV);
        pushByte(8'h07);
        operate(OP_REM);

        // Mixed signs.
        pushByte(8'h64);
        operate(OP_DUP);
        pushByte(8'hff);
        repeat (2) extendByte(8'hff);
        extendByte(8'hf9);
        operate(OP_DIV);
        operate(OP_SWAP);
        operate(OP_REM);
        pushByte(8'h03);
        operate(OP_REM);

        // Zero divisor leaves the stack alone.
        pushByte(8'h00);
        operate(OP_DIV);
        operate(OP_REM);
        operate(OP_POP);

        // A long hold is still one push.
        runCommand(PUSH_BTN, 8'h5a, 30, 34);
        operate(OP_SUB);
        operate(OP_MUL);
        clearStack();

        for (int i = 0; i < RANDOM_CMDS; i++) begin
            pick  = int'($urandom % 100);
            value = 8'($urandom);
            if (pick < 35)
                pushByte(value);
            else if (pick < 50)
                extendByte(value);
            else if (pick < 97)
                runCommand(OP_BTN, value, HOLD_CYCLES, GAP_CYCLES);
            else
                runCommand(CLEAR_BTN, value, HOLD_CYCLES, GAP_CYCLES);
        end

        // Fill to 511 entries, then overflow.
        clearStack();
        repeat (FILL_CMDS) runCommand(PUSH_BTN, 8'($urandom), FAST_HOLD, FAST_GAP);
        pushByte(8'haa);
        operate(OP_DUP);
        operate(OP_POP);
        clearStack();

        $display("Commands %0d, checks %0d, errors %0d", commandCount, checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* calcStack.f */
+incdir+src
src/calcPkg.sv
src/stackRam.sv
src/signedDivider.sv
src/buttonConditioner.sv
src/stackController.sv
src/calcTop.sv
verification/calcChecker.sv
verification/calcTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the calculator testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f calcStack.f --top-module calcTb -o calcSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/calcSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "No passing result found in $LOG."
exit 1
